/* src/st_glue_consts.svh */
// slot codes, io base addresses, auto vectors and bus error limit; include where a constant is used
`ifndef ST_GLUE_CONSTS_SVH
`define ST_GLUE_CONSTS_SVH

// bus slot codes, one slot per clk_8 cycle
`define ST_SLOT_VIDEO 2'd0
`define ST_SLOT_CPU   2'd1
`define ST_SLOT_IO    2'd2
`define ST_SLOT_SPARE 2'd3

// io base addresses, low 16 bits within the ff page
`define ST_IO_MMU   16'h8000  // mmu, 8 bit, ff8000-ff8001
`define ST_IO_VIDEO 16'h8200  // shifter regs, 16 bit, ff8200-ff827f
`define ST_IO_DMA   16'h8600  // dma / fdc, 16 bit, ff8600-ff860f
`define ST_IO_PSG   16'h8800  // ym2149, upper byte
`define ST_IO_MFP   16'hfa00  // 68901, lower byte, fffa00-fffa3f
`define ST_IO_ACIA  16'hfc00  // ikbd and midi acias, upper byte

// vectors handed out for the autovector levels
`define ST_VEC_VBI 8'h1c  // level 4
`define ST_VEC_HBI 8'h1a  // level 2

// unanswered cpu slots before bus error
`define ST_BERR_LIMIT 3'd7

`endif

/* src/st_glue_pkg.sv */
// shared types of the bus glue; imported by every glue module
`include "st_glue_consts.svh"

package st_glue_pkg;

	typedef logic [23:0] cpu_addr_t;  // byte address
	typedef logic [22:0] ram_addr_t;  // word address
	typedef logic [15:0] bus_data_t;
	typedef logic [7:0]  io_byte_t;
	typedef logic [2:0]  ipl_t;       // active low level
	typedef logic [3:0]  berr_cnt_t;

	typedef enum logic [1:0] {
		SLOT_VIDEO = `ST_SLOT_VIDEO,
		SLOT_CPU   = `ST_SLOT_CPU,
		SLOT_IO    = `ST_SLOT_IO,
		SLOT_SPARE = `ST_SLOT_SPARE
	} bus_slot_t;

	// st ram size, same order as the config word
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_cfg_t;

	typedef struct packed {
		cpu_addr_t addr;
		bus_data_t wdata;
		logic      as_n;
		logic      uds_n;
		logic      lds_n;
		logic      rw;        // 1 = read
		logic      clr_berr;  // cpu done with bus error
	} cpu_bus_t;

	typedef struct packed {
		logic mmu;
		logic vreg;
		logic dma;
		logic psg;
		logic mfp;
		logic acia;
		logic mfp_iack;   // level 6 ack
		logic auto_iack;  // level 4 or 2 ack
	} io_sel_t;

	typedef struct packed {
		bus_data_t vreg;
		bus_data_t dma;
		io_byte_t  mmu;
		io_byte_t  mfp;
		io_byte_t  acia;
		io_byte_t  psg;
	} io_rdata_t;

	typedef struct packed {
		ram_addr_t addr;
		logic      oe_n;
		logic      wr_n;
		logic      uds_n;
		logic      lds_n;
	} ram_ctrl_t;

endpackage

/* src/mem_map_decode.sv */
// cpu address decode into ram, rom, io and ack regions plus the peripheral selects
`timescale 1ns/1ns
`include "st_glue_consts.svh"

module mem_map_decode
	import st_glue_pkg::*;
(
	input  cpu_bus_t  cpu_bus,
	input  mem_cfg_t  mem_cfg,
	input  bus_slot_t slot,
	input  logic      addr_strobe,
	output logic      to_mem,
	output logic      to_ram,
	output logic      to_iack,
	output io_sel_t   io_sel
);

	cpu_addr_t a;
	logic ram_4m, ram_8m, ram_12m;  // ram banks
	logic ram_14m;                  // any ram, ignoring size
	logic tos_256k, tos_192k, cart;
	logic to_io;
	logic io_cyc, iack_cyc;

	assign a = cpu_bus.addr;

	assign ram_4m  = (a[23:22] == 2'b00);  // 000000-3fffff
	assign ram_8m  = (a[23:22] == 2'b01);
	assign ram_12m = (a[23:22] == 2'b10) || (a[23:21] == 3'b110);  // up to dfffff
	assign ram_14m = ram_4m || ram_8m || ram_12m;

	assign tos_256k = (a[23:18] == 6'b111000);                          // e00000
	assign tos_192k = (a[23:17] == 7'b1111110) || (a[23:16] == 8'hfe);  // fc0000-feffff
	assign cart     = (a[23:17] == 7'b1111101);                         // fa0000-fbffff

	// reads hit all of ram and rom, writes only ram
	assign to_mem  = ram_14m || (cpu_bus.rw && (tos_256k || tos_192k || cart));
	assign to_io   = (a[23:16] == 8'hff);
	assign to_iack = (a[23:4] == 20'hfffff);

	// writable ram depends on fitted size
	always_comb begin
		case (mem_cfg)
			MEM_8M:  to_ram = ram_4m || ram_8m;
			MEM_14M: to_ram = ram_14m;
			default: to_ram = ram_4m;  // smaller configs decode 4MB
		endcase
	end

	assign io_cyc   = (slot == SLOT_CPU) && addr_strobe && to_io;
	assign iack_cyc = (slot == SLOT_CPU) && addr_strobe && to_iack;

	// each select masks the address bits inside the device window
	assign io_sel.mmu  = io_cyc && ({a[15:1], 1'b0} == `ST_IO_MMU);
	assign io_sel.vreg = io_cyc && ({a[15:7], 7'd0} == `ST_IO_VIDEO);
	assign io_sel.dma  = io_cyc && ({a[15:4], 4'd0} == `ST_IO_DMA);
	assign io_sel.psg  = io_cyc && ({a[15:8], 8'd0} == `ST_IO_PSG);
	assign io_sel.mfp  = io_cyc && ({a[15:6], 6'd0} == `ST_IO_MFP);
	assign io_sel.acia = io_cyc && ({a[15:8], 8'd0} == `ST_IO_ACIA);

	// level sits in a[3:1] during ack
	assign io_sel.mfp_iack  = iack_cyc && (a[3:1] == 3'd6);
	assign io_sel.auto_iack = iack_cyc && ((a[3:1] == 3'd4) || (a[3:1] == 3'd2));

endmodule

/* src/bus_slot_ctrl.sv */
// slot sequencer, address strobe, st ram port muxing, dtack and cpu read data
`timescale 1ns/1ns

module bus_slot_ctrl
	import st_glue_pkg::*;
(
	input  logic      clk_8,
	input  logic      pll_locked,
	input  logic      soft_reset,
	input  cpu_bus_t  cpu_bus,
	input  logic      br,
	input  logic      to_mem,
	input  logic      to_ram,
	input  io_sel_t   io_sel,
	input  io_rdata_t io_rdata,
	input  io_byte_t  auto_vector,
	input  ram_addr_t video_addr,
	input  logic      video_read,
	input  bus_data_t ram_rdata,
	output bus_slot_t slot,
	output logic      addr_strobe,
	output logic      cpu_dtack_n,
	output bus_data_t cpu_rdata,
	output ram_ctrl_t ram_ctrl
);

	io_byte_t  io_lo, io_hi;  // byte lanes
	bus_data_t io_data;
	logic      io_dtack;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot        <= SLOT_VIDEO;
			addr_strobe <= 1'b0;
		end else if (soft_reset) begin
			slot        <= SLOT_VIDEO;
			addr_strobe <= 1'b0;
		end else begin
			slot <= bus_slot_t'(slot + 2'd1);  // wraps every 4
			// taken at end of video slot, so high for the cpu slot only
			addr_strobe <= (slot == SLOT_VIDEO) && !cpu_bus.as_n && !br;
		end
	end

	assign io_dtack = |io_sel;  // every select incl. acks answers

	// br stalls the cpu by withholding dtack
	assign cpu_dtack_n = ~(((to_mem && addr_strobe) || io_dtack) && !br);

	always_comb begin
		ram_ctrl.addr  = cpu_bus.addr[23:1];
		ram_ctrl.oe_n  = 1'b1;
		ram_ctrl.wr_n  = 1'b1;
		ram_ctrl.uds_n = cpu_bus.uds_n;
		ram_ctrl.lds_n = cpu_bus.lds_n;
		case (slot)
			SLOT_VIDEO: begin
				ram_ctrl.addr  = video_addr;
				ram_ctrl.oe_n  = video_read;  // both active low
				ram_ctrl.uds_n = 1'b0;        // video reads full words
				ram_ctrl.lds_n = 1'b0;
			end
			SLOT_CPU: begin
				ram_ctrl.oe_n = ~(addr_strobe && cpu_bus.rw && to_mem);
				ram_ctrl.wr_n = ~(addr_strobe && !cpu_bus.rw && to_ram);
			end
			default: ;  // io and spare leave ram idle
		endcase
	end

	// unselected peripherals return zero, so plain OR
	assign io_hi   = io_rdata.acia | io_rdata.psg;
	assign io_lo   = io_rdata.mmu | io_rdata.mfp | auto_vector;
	assign io_data = io_rdata.vreg | io_rdata.dma | {io_hi, io_lo};

	assign cpu_rdata = to_mem ? ram_rdata : io_data;

endmodule

/* src/berr_timeout.sv */
// dtack timeout raising the cpu bus error, plus bus error event counter for debug
`timescale 1ns/1ns
`include "st_glue_consts.svh"

module berr_timeout
	import st_glue_pkg::*;
(
	input  logic      clk_8,
	input  logic      pll_locked,
	input  logic      soft_reset,
	input  bus_slot_t slot,
	input  cpu_bus_t  cpu_bus,
	input  logic      cpu_dtack_n,
	input  logic      br,
	output logic      cpu_berr,
	output berr_cnt_t berr_count
);

	logic [2:0] timeout;  // unanswered cpu slots, saturates
	logic       berr_d;

	assign cpu_berr = (timeout == `ST_BERR_LIMIT);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout <= 3'd0;
		end else if (soft_reset) begin
			timeout <= 3'd0;
		end else if (slot == SLOT_CPU) begin
			if (!cpu_berr) begin
				// count only a pending access the cpu still owns
				if (!cpu_dtack_n || br || cpu_bus.as_n)
					timeout <= 3'd0;
				else
					timeout <= timeout + 3'd1;
			end else if (cpu_bus.clr_berr) begin
				timeout <= 3'd0;  // exception taken
			end
		end
	end

	// one count per rising berr
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			berr_d     <= 1'b0;
			berr_count <= '0;
		end else if (soft_reset) begin
			berr_d     <= 1'b0;
			berr_count <= '0;
		end else begin
			berr_d <= cpu_berr;
			if (cpu_berr && !berr_d)
				berr_count <= berr_count + 4'd1;
		end
	end

endmodule

/* src/irq_ctrl.sv */
// vbi and hbi edge detect, pending latches, ipl priority encode and autovector byte
`timescale 1ns/1ns
`include "st_glue_consts.svh"

module irq_ctrl
	import st_glue_pkg::*;
(
	input  logic     clk_8,
	input  logic     pll_locked,
	input  logic     soft_reset,
	input  logic     vs,
	input  logic     hs,
	input  logic     mfp_irq,
	input  cpu_bus_t cpu_bus,
	input  logic     to_iack,
	input  logic     addr_strobe,
	output ipl_t     cpu_ipl,
	output io_byte_t auto_vector
);

	// bit 0 vs, bit 1 hs
	logic [1:0] blank_s;     // falling edge sample
	logic [1:0] blank_d1, blank_d2;
	logic [1:0] blank_rise;  // one cycle pulse
	logic       vbi, hbi;
	logic       vbi_ack, hbi_ack;

	// strobe is only high in the cpu slot
	assign vbi_ack = to_iack && addr_strobe && (cpu_bus.addr[3:1] == 3'd4);
	assign hbi_ack = to_iack && addr_strobe && (cpu_bus.addr[3:1] == 3'd2);

	assign auto_vector = vbi_ack ? `ST_VEC_VBI :
		hbi_ack ? `ST_VEC_HBI : 8'h00;

	always_ff @(negedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			blank_s <= 2'b00;
		else
			blank_s <= {hs, vs};
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			blank_d1   <= 2'b00;
			blank_d2   <= 2'b00;
			blank_rise <= 2'b00;
			vbi        <= 1'b0;
			hbi        <= 1'b0;
		end else if (soft_reset) begin
			blank_d1   <= 2'b00;
			blank_d2   <= 2'b00;
			blank_rise <= 2'b00;
			vbi        <= 1'b0;
			hbi        <= 1'b0;
		end else begin
			blank_d1   <= blank_s;
			blank_d2   <= blank_d1;
			blank_rise <= blank_d1 & ~blank_d2;
			// ack wins over a new edge
			if (vbi_ack)
				vbi <= 1'b0;
			else if (blank_rise[0])
				vbi <= 1'b1;
			if (hbi_ack)
				hbi <= 1'b0;
			else if (blank_rise[1])
				hbi <= 1'b1;
		end
	end

	// ipl[0] tied high like the real st
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			cpu_ipl <= 3'b111;
		else if (soft_reset)
			cpu_ipl <= 3'b111;
		else if (mfp_irq)
			cpu_ipl <= 3'b001;  // level 6
		else if (vbi)
			cpu_ipl <= 3'b011;  // level 4
		else if (hbi)
			cpu_ipl <= 3'b101;  // level 2
		else
			cpu_ipl <= 3'b111;
	end

endmodule

/* src/st_glue.sv */
// top of the st bus glue, connects decode, slot control, bus error and interrupt blocks
`timescale 1ns/1ns

module st_glue
	import st_glue_pkg::*;
(
	input  logic      clk_8,
	input  logic      pll_locked,
	input  logic      soft_reset,
	input  mem_cfg_t  mem_cfg,
	input  cpu_bus_t  cpu_bus,
	input  logic      br,          // host loader owns the bus
	input  logic      vs,
	input  logic      hs,
	input  logic      mfp_irq,
	input  io_rdata_t io_rdata,
	input  ram_addr_t video_addr,
	input  logic      video_read,  // active low
	input  bus_data_t ram_rdata,
	output logic      cpu_dtack_n,
	output logic      cpu_berr,
	output ipl_t      cpu_ipl,
	output bus_data_t cpu_rdata,
	output io_sel_t   io_sel,
	output ram_ctrl_t ram_ctrl,
	output berr_cnt_t berr_count
);

	bus_slot_t slot;
	logic      addr_strobe;
	logic      to_mem, to_ram, to_iack;
	io_byte_t  auto_vector;

	mem_map_decode u_decode (
		.cpu_bus     (cpu_bus),
		.mem_cfg     (mem_cfg),
		.slot        (slot),
		.addr_strobe (addr_strobe),
		.to_mem      (to_mem),
		.to_ram      (to_ram),
		.to_iack     (to_iack),
		.io_sel      (io_sel)
	);

	bus_slot_ctrl u_slot (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.soft_reset  (soft_reset),
		.cpu_bus     (cpu_bus),
		.br          (br),
		.to_mem      (to_mem),
		.to_ram      (to_ram),
		.io_sel      (io_sel),
		.io_rdata    (io_rdata),
		.auto_vector (auto_vector),
		.video_addr  (video_addr),
		.video_read  (video_read),
		.ram_rdata   (ram_rdata),
		.slot        (slot),
		.addr_strobe (addr_strobe),
		.cpu_dtack_n (cpu_dtack_n),
		.cpu_rdata   (cpu_rdata),
		.ram_ctrl    (ram_ctrl)
	);

	berr_timeout u_berr (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.soft_reset  (soft_reset),
		.slot        (slot),
		.cpu_bus     (cpu_bus),
		.cpu_dtack_n (cpu_dtack_n),
		.br          (br),
		.cpu_berr    (cpu_berr),
		.berr_count  (berr_count)
	);

	irq_ctrl u_irq (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.soft_reset  (soft_reset),
		.vs          (vs),
		.hs          (hs),
		.mfp_irq     (mfp_irq),
		.cpu_bus     (cpu_bus),
		.to_iack     (to_iack),
		.addr_strobe (addr_strobe),
		.cpu_ipl     (cpu_ipl),
		.auto_vector (auto_vector)
	);

endmodule

/* testbench/st_glue_tb.sv */
// self-checking testbench of the st bus glue; compile with st_glue.f, st_glue_tb is the top
`timescale 1ns/1ns

module st_glue_tb
	import st_glue_pkg::*;
();

	logic      clk_8, pll_locked, soft_reset;
	mem_cfg_t  mem_cfg;
	cpu_bus_t  cpu_bus;
	logic      br, vs, hs, mfp_irq;
	io_rdata_t io_rdata;
	ram_addr_t video_addr;
	logic      video_read;
	bus_data_t ram_rdata;
	logic      cpu_dtack_n, cpu_berr;
	ipl_t      cpu_ipl;
	bus_data_t cpu_rdata;
	io_sel_t   io_sel;
	ram_ctrl_t ram_ctrl;
	berr_cnt_t berr_count;

	bus_slot_t exp_slot;  // own copy of the slot sequence
	bus_data_t per_data;  // what a selected peripheral answers
	integer    seed = 39;
	integer    errors = 0;
	integer    checks = 0;

	// one decode row of access, config and expected bus response
	typedef struct packed {
		cpu_addr_t  addr;
		logic       rw;
		logic [2:0] cfg;
		logic       dtack_n;
		logic       oe_n;
		logic       wr_n;
		logic [7:0] sel;  // mmu vreg dma psg mfp acia mfp_iack auto_iack
	} decode_vec_t;

	decode_vec_t vectors[$];

	st_glue u_dut (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.soft_reset  (soft_reset),
		.mem_cfg     (mem_cfg),
		.cpu_bus     (cpu_bus),
		.br          (br),
		.vs          (vs),
		.hs          (hs),
		.mfp_irq     (mfp_irq),
		.io_rdata    (io_rdata),
		.video_addr  (video_addr),
		.video_read  (video_read),
		.ram_rdata   (ram_rdata),
		.cpu_dtack_n (cpu_dtack_n),
		.cpu_berr    (cpu_berr),
		.cpu_ipl     (cpu_ipl),
		.cpu_rdata   (cpu_rdata),
		.io_sel      (io_sel),
		.ram_ctrl    (ram_ctrl),
		.berr_count  (berr_count)
	);

	initial begin
		clk_8 = 1'b0;
		forever #2 clk_8 = ~clk_8;  // 4 ns period
	end

	// video first after reset then one slot per clock
	always @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			exp_slot <= SLOT_VIDEO;
		else if (soft_reset)
			exp_slot <= SLOT_VIDEO;
		else
			exp_slot <= bus_slot_t'(exp_slot + 2'd1);
	end

	// peripherals answer only while selected
	always_comb begin
		io_rdata = '0;
		if (io_sel.mmu)  io_rdata.mmu  = per_data[7:0];
		if (io_sel.vreg) io_rdata.vreg = per_data;
		if (io_sel.dma)  io_rdata.dma  = per_data;
		if (io_sel.psg)  io_rdata.psg  = per_data[7:0];
		if (io_sel.mfp)  io_rdata.mfp  = per_data[7:0];
		if (io_sel.acia) io_rdata.acia = per_data[7:0];
	end

	task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errors = errors + 1;
		end
	endtask

	task next_cycle;
		@(posedge clk_8);
		#1;  // inputs change and outputs settle 1 ns after the edge
	endtask

	task wait_for_slot(input bus_slot_t s);
		integer n;
		n = 0;
		do begin
			next_cycle;
			n = n + 1;
		end while (exp_slot != s && n < 8);
		if (exp_slot != s) begin
			$display("timeout waiting for bus slot %0d", s);
			errors = errors + 1;
		end
	endtask

	task set_bus_idle;
		cpu_bus.as_n     = 1'b1;
		cpu_bus.uds_n    = 1'b1;
		cpu_bus.lds_n    = 1'b1;
		cpu_bus.rw       = 1'b1;
		cpu_bus.clr_berr = 1'b0;
	endtask

	// strobe goes low in the video slot and returns inside the cpu slot
	task start_access(input cpu_addr_t addr, input logic rw);
		wait_for_slot(SLOT_VIDEO);
		cpu_bus.addr  = addr;
		cpu_bus.rw    = rw;
		cpu_bus.wdata = $random(seed);
		cpu_bus.as_n  = 1'b0;
		cpu_bus.uds_n = 1'b0;
		cpu_bus.lds_n = 1'b0;
		wait_for_slot(SLOT_CPU);
	endtask

	task wait_ipl(input ipl_t lvl);
		integer n;
		n = 0;
		while (cpu_ipl !== lvl && n < 20) begin
			next_cycle;
			n = n + 1;
		end
		if (cpu_ipl !== lvl) begin
			$display("timeout waiting for interrupt level %0d", lvl);
			errors = errors + 1;
		end
	endtask

	function automatic void add_vector(input cpu_addr_t a, input logic rw, input logic [2:0] cfg,
		input logic dtack_n, input logic oe_n, input logic wr_n, input logic [7:0] sel);
		vectors.push_back({a, rw, cfg, dtack_n, oe_n, wr_n, sel});
	endfunction

	// read data the cpu must see for peripheral idx answering d
	function automatic bus_data_t expected_io_word(input integer idx, input bus_data_t d);
		case (idx)
			1, 2:    return d;                  // word registers
			3, 5:    return {d[7:0], 8'h00};    // psg and acia on the upper lane
			default: return {8'h00, d[7:0]};    // mmu and mfp on the lower lane
		endcase
	endfunction

	initial begin
		integer    i, n;
		string     name;
		bus_data_t exp_word;
		cpu_addr_t io_addr [6];

		pll_locked = 1'b0;
		soft_reset = 1'b0;
		mem_cfg    = MEM_4M;
		cpu_bus    = '0;
		set_bus_idle;
		br         = 1'b0;
		vs         = 1'b0;
		hs         = 1'b0;
		mfp_irq    = 1'b0;
		video_addr = '0;
		video_read = 1'b1;
		ram_rdata  = '0;
		per_data   = '0;

		repeat (10) @(posedge clk_8);
		#1 pll_locked = 1'b1;
		next_cycle;

		// 1. reset values
		check("reset dtack_n", 1, cpu_dtack_n);
		check("reset berr", 0, cpu_berr);
		check("reset ipl", 7, cpu_ipl);
		check("reset oe_n", 1, ram_ctrl.oe_n);
		check("reset wr_n", 1, ram_ctrl.wr_n);
		check("reset berr_count", 0, berr_count);

		// 2. decode table   addr rw cfg dtack_n oe_n wr_n sel
		add_vector(24'h000100, 1, MEM_4M,   0, 0, 1, 8'h00);
		add_vector(24'h000100, 0, MEM_512K, 0, 1, 0, 8'h00);
		add_vector(24'h500000, 0, MEM_4M,   0, 1, 1, 8'h00);  // beyond fitted ram
		add_vector(24'h500000, 0, MEM_8M,   0, 1, 0, 8'h00);
		add_vector(24'h500000, 0, MEM_14M,  0, 1, 0, 8'h00);
		add_vector(24'hc00000, 0, MEM_8M,   0, 1, 1, 8'h00);
		add_vector(24'hc00000, 0, MEM_14M,  0, 1, 0, 8'h00);
		add_vector(24'hc00000, 1, MEM_512K, 0, 0, 1, 8'h00);  // reads see all 14MB
		add_vector(24'he00000, 1, MEM_4M,   0, 0, 1, 8'h00);  // tos
		add_vector(24'he00000, 0, MEM_4M,   1, 1, 1, 8'h00);  // rom write gets no dtack
		add_vector(24'hfc0000, 1, MEM_4M,   0, 0, 1, 8'h00);
		add_vector(24'hfc0000, 0, MEM_4M,   1, 1, 1, 8'h00);
		add_vector(24'hfa0000, 1, MEM_4M,   0, 0, 1, 8'h00);  // cartridge
		add_vector(24'hff8000, 1, MEM_4M,   0, 1, 1, 8'h80);
		add_vector(24'hff8240, 1, MEM_4M,   0, 1, 1, 8'h40);
		add_vector(24'hff8604, 1, MEM_4M,   0, 1, 1, 8'h20);
		add_vector(24'hff8800, 1, MEM_4M,   0, 1, 1, 8'h10);
		add_vector(24'hff8800, 0, MEM_4M,   0, 1, 1, 8'h10);
		add_vector(24'hfffa10, 1, MEM_4M,   0, 1, 1, 8'h08);
		add_vector(24'hfffc02, 1, MEM_4M,   0, 1, 1, 8'h04);
		add_vector(24'hfffffc, 1, MEM_4M,   0, 1, 1, 8'h02);  // level 6 ack
		add_vector(24'hfffff8, 1, MEM_4M,   0, 1, 1, 8'h01);  // level 4 ack
		add_vector(24'hfffff4, 1, MEM_4M,   0, 1, 1, 8'h01);  // level 2 ack
		add_vector(24'hff9000, 1, MEM_4M,   1, 1, 1, 8'h00);  // nothing there
		for (i = 0; i < vectors.size(); i = i + 1) begin
			mem_cfg = mem_cfg_t'(vectors[i].cfg);
			start_access(vectors[i].addr, vectors[i].rw);
			name = $sformatf("decode %h rw %0d cfg %0d", vectors[i].addr, vectors[i].rw,
				vectors[i].cfg);
			check({name, " dtack_n"}, vectors[i].dtack_n, cpu_dtack_n);
			check({name, " oe_n"}, vectors[i].oe_n, ram_ctrl.oe_n);
			check({name, " wr_n"}, vectors[i].wr_n, ram_ctrl.wr_n);
			check({name, " io_sel"}, vectors[i].sel, io_sel);
			set_bus_idle;
		end
		mem_cfg = MEM_4M;

		// 3. read data paths
		ram_rdata = $random(seed);
		start_access(24'h000200, 1);
		check("ram read data", ram_rdata, cpu_rdata);
		check("ram read addr", 23'h000100, ram_ctrl.addr);  // word address of 000200
		set_bus_idle;
		io_addr = '{24'hff8000, 24'hff8240, 24'hff8604, 24'hff8800, 24'hfffa10, 24'hfffc02};
		for (i = 0; i < 6; i = i + 1) begin
			per_data = $random(seed);
			exp_word = expected_io_word(i, per_data);
			start_access(io_addr[i], 1);
			check($sformatf("io read %h", io_addr[i]), exp_word, cpu_rdata);
			set_bus_idle;
		end
		video_addr = $random(seed);
		video_read = 1'b0;
		wait_for_slot(SLOT_VIDEO);
		check("video addr", video_addr, ram_ctrl.addr);
		check("video oe_n", 0, ram_ctrl.oe_n);
		check("video strobes", 0, {ram_ctrl.uds_n, ram_ctrl.lds_n});
		video_read = 1'b1;

		// 4. bus request holds off the cpu
		br = 1'b1;
		start_access(24'hff8800, 1);
		check("br io dtack_n", 1, cpu_dtack_n);
		check("br io_sel", 0, io_sel);
		check("br oe_n", 1, ram_ctrl.oe_n);
		set_bus_idle;
		start_access(24'h000400, 0);
		check("br ram dtack_n", 1, cpu_dtack_n);
		check("br wr_n", 1, ram_ctrl.wr_n);
		set_bus_idle;
		br = 1'b0;

		// 5. unanswered io access times out 25 cycles after the strobe edge
		start_access(24'hff9000, 1);
		n = 0;
		while (!cpu_berr && n < 40) begin
			next_cycle;
			n = n + 1;
		end
		if (!cpu_berr) begin
			$display("bus error was never raised for the unmapped io access");
			errors = errors + 1;
		end else begin
			check("berr delay", 25, n);
			check("berr_count before", 0, berr_count);
			next_cycle;
			check("berr_count after", 1, berr_count);
		end
		set_bus_idle;
		cpu_bus.clr_berr = 1'b1;
		n = 0;
		while (cpu_berr && n < 12) begin
			next_cycle;
			n = n + 1;
		end
		if (cpu_berr) begin
			$display("clr_berr did not release the bus error");
			errors = errors + 1;
		end
		cpu_bus.clr_berr = 1'b0;
		check("berr_count held", 1, berr_count);

		// 6. hbi then vbi then mfp on top
		hs = 1'b1;
		repeat (3) next_cycle;
		hs = 1'b0;
		wait_ipl(3'd5);
		vs = 1'b1;
		repeat (3) next_cycle;
		vs = 1'b0;
		wait_ipl(3'd3);
		mfp_irq = 1'b1;
		wait_ipl(3'd1);
		mfp_irq = 1'b0;
		wait_ipl(3'd3);
		start_access(24'hfffff8, 1);  // level 4 ack
		check("vbi vector", 16'h001c, cpu_rdata);
		check("vbi ack dtack_n", 0, cpu_dtack_n);
		set_bus_idle;
		wait_ipl(3'd5);  // vbi gone so hbi is left
		start_access(24'hfffff4, 1);  // level 2 ack
		check("hbi vector", 16'h001a, cpu_rdata);
		set_bus_idle;
		wait_ipl(3'd7);

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* st_glue.f */
+incdir+src
src/st_glue_pkg.sv
src/mem_map_decode.sv
src/bus_slot_ctrl.sv
src/berr_timeout.sv
src/irq_ctrl.sv
src/st_glue.sv
testbench/st_glue_tb.sv

/* Bender.yml */
package:
  name: st_glue

sources:
  - include_dirs:
      - src
    files:
      - src/st_glue_pkg.sv
      - src/mem_map_decode.sv
      - src/bus_slot_ctrl.sv
      - src/berr_timeout.sv
      - src/irq_ctrl.sv
      - src/st_glue.sv
  - target: simulation
    files:
      - testbench/st_glue_tb.sv
